// File: fe_defs.svh
`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// width of pc and instruction words
`define FE_XLEN 32

// first fetch address after reset
`define FE_PC_RESET 32'h0000_0000

// fetch queue entries, power of two only
// 4 leaves room for the one request in flight plus a few buffered words
`define FE_FQ_DEPTH 4

`endif

// File: fe_pkg.sv
`include "fe_defs.svh"

package fe_pkg;

  // one fetched word with the address it came from
  typedef struct packed {
    logic [`FE_XLEN-1:0] pc;    // fetch address
    logic [`FE_XLEN-1:0] inst;  // raw instruction word
  } fetch_entry_t;

  // source that picked the next fetch address
  typedef enum logic [1:0] {
    REDIR_SEQ    = 2'd0,  // pc + 4
    REDIR_JAL    = 2'd1,  // predecode jump target
    REDIR_BRANCH = 2'd2,  // branch resolved downstream
    REDIR_TRAP   = 2'd3   // trap / exception vector
  } redirect_src_e;

endpackage

// File: pc_gen.sv
`include "fe_defs.svh"

module pc_gen import fe_pkg::*; (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                stall_i,         // queue nearly full
  input  logic                trap_valid_i,
  input  logic [`FE_XLEN-1:0] trap_pc_i,
  input  logic                branch_valid_i,
  input  logic [`FE_XLEN-1:0] branch_pc_i,
  input  logic                jal_valid_i,     // from predecode
  input  logic [`FE_XLEN-1:0] jal_pc_i,
  output logic [`FE_XLEN-1:0] fetch_addr_o,
  output logic                fetch_req_o,
  output logic [`FE_XLEN-1:0] pc_o,            // last loaded pc
  output logic                flush_o,
  output redirect_src_e       redirect_src_o
);

  logic [`FE_XLEN-1:0] pc_q;
  logic                fetched_q;  // pc_q already sent to memory
  logic                run_q;      // out of reset
  logic [`FE_XLEN-1:0] seq_pc;
  logic [`FE_XLEN-1:0] next_pc;
  logic                redirect;
  logic                pc_load;

  // right after reset or a stalled redirect pc_q itself still needs fetching
  assign seq_pc = fetched_q ? pc_q + `FE_XLEN'd4 : pc_q;

  // fixed priority, trap > branch > jal > sequential
  always_comb begin
    if (trap_valid_i) begin
      next_pc        = trap_pc_i;
      redirect_src_o = REDIR_TRAP;
    end else if (branch_valid_i) begin
      next_pc        = branch_pc_i;
      redirect_src_o = REDIR_BRANCH;
    end else if (jal_valid_i) begin
      next_pc        = jal_pc_i;
      redirect_src_o = REDIR_JAL;
    end else begin
      next_pc        = seq_pc;
      redirect_src_o = REDIR_SEQ;
    end
  end

  assign redirect = run_q & (trap_valid_i | branch_valid_i | jal_valid_i);
  assign flush_o  = redirect;  // drops queue contents and in-flight word

  assign fetch_req_o = run_q & ~stall_i;
  // stalled: present the held pc, no request goes out
  assign fetch_addr_o = (stall_i & ~redirect) ? pc_q : next_pc;

  // redirects override the stall so the target is not lost
  assign pc_load = fetch_req_o | redirect;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q      <= `FE_PC_RESET;
      fetched_q <= 1'b0;
      run_q     <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (pc_load) begin
        pc_q      <= next_pc;
        fetched_q <= fetch_req_o;  // low if loaded during a stall
      end
    end
  end

  assign pc_o = pc_q;

endmodule

// File: fetch_queue.sv
`include "fe_defs.svh"

module fetch_queue #(
  parameter type payload_t = logic [`FE_XLEN-1:0],
  parameter int  DEPTH     = `FE_FQ_DEPTH  // power of two
) (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     flush_i,       // empties queue, same-cycle write dropped
  input  logic     wr_valid_i,
  input  payload_t wr_data_i,
  input  logic     rd_pop_i,
  output payload_t rd_data_o,     // head entry
  output logic     not_empty_o,
  output logic     almost_full_o  // one slot or less left
);

  localparam int PTR_W = $clog2(DEPTH);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;    // one extra bit so full is representable
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full        = (count_q == DEPTH[PTR_W:0]);
  assign not_empty_o = (count_q != '0);
  // leaves room for the request already in flight
  assign almost_full_o = (count_q >= DEPTH[PTR_W:0] - 1'b1);

  assign rd_en = rd_pop_i & not_empty_o;
  // a pop frees the slot in the same cycle
  assign wr_en = wr_valid_i & ~flush_i & (~full | rd_en);

  // payload storage, pointers guard validity
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at DEPTH
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  assign rd_data_o = mem[rd_ptr_q];

endmodule

// File: jal_predecode.sv
`include "fe_defs.svh"

module jal_predecode import fe_pkg::*; (
  input  logic                entry_valid_i,  // queue not empty
  input  fetch_entry_t        entry_i,        // queue head
  input  logic                hold_i,         // decode not ready
  output logic                pop_o,
  output logic                issue_valid_o,
  output logic [`FE_XLEN-1:0] issue_pc_o,
  output logic [`FE_XLEN-1:0] issue_inst_o,
  output logic                jal_valid_o,
  output logic [`FE_XLEN-1:0] jal_pc_o        // jump target
);

  localparam logic [6:0] OPC_JAL = 7'b110_1111;

  logic [`FE_XLEN-1:0] inst;
  logic                is_jal;
  logic [`FE_XLEN-1:0] j_imm;

  assign inst   = entry_i.inst;
  assign is_jal = (inst[6:0] == OPC_JAL);

  // J-type immediate, bits scattered over the word
  // imm[20] imm[10:1] imm[11] imm[19:12] at inst[31] [30:21] [20] [19:12]
  assign j_imm = {{(`FE_XLEN-20){inst[31]}},  // sign, incl imm[20]
                  inst[19:12],                 // imm[19:12]
                  inst[20],                    // imm[11]
                  inst[30:21],                 // imm[10:1]
                  1'b0};                       // halfword aligned

  // one pop per cycle, no skid
  assign pop_o         = entry_valid_i & ~hold_i;
  assign issue_valid_o = pop_o;
  assign issue_pc_o    = entry_i.pc;
  assign issue_inst_o  = inst;

  // redirect only when the jal actually leaves the queue
  assign jal_valid_o = pop_o & is_jal;
  assign jal_pc_o    = entry_i.pc + j_imm;  // pc relative

endmodule

// File: fetch_frontend.sv
`include "fe_defs.svh"

module fetch_frontend import fe_pkg::*; (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                trap_valid_i,
  input  logic [`FE_XLEN-1:0] trap_pc_i,
  input  logic                branch_valid_i,
  input  logic [`FE_XLEN-1:0] branch_pc_i,
  input  logic                hold_i,
  output logic                imem_req_o,
  output logic [`FE_XLEN-1:0] imem_addr_o,
  input  logic [`FE_XLEN-1:0] imem_rdata_i,  // one cycle after request
  output logic                issue_valid_o,
  output logic [`FE_XLEN-1:0] issue_pc_o,
  output logic [`FE_XLEN-1:0] issue_inst_o,
  output redirect_src_e       redirect_src_o
);

  logic                stall;
  logic                flush;
  logic [`FE_XLEN-1:0] pc_q;       // address of the word now returning
  logic                inflight_q; // request sent last cycle
  logic                wr_valid;
  fetch_entry_t        wr_entry;
  fetch_entry_t        head;
  logic                not_empty;
  logic                pop;
  logic                jal_valid;
  logic [`FE_XLEN-1:0] jal_target;

  pc_gen pc_gen_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .stall_i        (stall),
    .trap_valid_i   (trap_valid_i),
    .trap_pc_i      (trap_pc_i),
    .branch_valid_i (branch_valid_i),
    .branch_pc_i    (branch_pc_i),
    .jal_valid_i    (jal_valid),
    .jal_pc_i       (jal_target),
    .fetch_addr_o   (imem_addr_o),
    .fetch_req_o    (imem_req_o),
    .pc_o           (pc_q),
    .flush_o        (flush),
    .redirect_src_o (redirect_src_o)
  );

  // tracks the single outstanding memory read
  always_ff @(posedge clk) begin
    if (rst_i) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= imem_req_o;  // on flush this is already the target fetch
    end
  end

  // stale response in a flush cycle is masked here and dropped by the queue
  assign wr_valid      = inflight_q & ~flush;
  assign wr_entry.pc   = pc_q;
  assign wr_entry.inst = imem_rdata_i;

  fetch_queue #(
    .payload_t (fetch_entry_t),
    .DEPTH     (`FE_FQ_DEPTH)
  ) fetch_queue_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .flush_i       (flush),
    .wr_valid_i    (wr_valid),
    .wr_data_i     (wr_entry),
    .rd_pop_i      (pop),
    .rd_data_o     (head),
    .not_empty_o   (not_empty),
    .almost_full_o (stall)
  );

  jal_predecode jal_predecode_i (
    .entry_valid_i (not_empty),
    .entry_i       (head),
    .hold_i        (hold_i),
    .pop_o         (pop),
    .issue_valid_o (issue_valid_o),
    .issue_pc_o    (issue_pc_o),
    .issue_inst_o  (issue_inst_o),
    .jal_valid_o   (jal_valid),
    .jal_pc_o      (jal_target)
  );

endmodule

// File: fetch_frontend_tb.sv
`include "fe_defs.svh"

module fetch_frontend_tb import fe_pkg::*; ();

  localparam int PERIOD   = 40;
  localparam int DRV      = 2;   // input drive delay after posedge
  localparam int DEPTH    = `FE_FQ_DEPTH;
  localparam int TAIL     = 40;  // cycles run past the last event
  localparam int MAX_MEM  = 64;
  localparam int MAX_EV   = 64;
  localparam int IDLE_MAX = 16;

  logic                clk;
  logic                rst_i;
  logic                trap_valid_i;
  logic [`FE_XLEN-1:0] trap_pc_i;
  logic                branch_valid_i;
  logic [`FE_XLEN-1:0] branch_pc_i;
  logic                hold_i;
  logic                imem_req_o;
  logic [`FE_XLEN-1:0] imem_addr_o;
  logic [`FE_XLEN-1:0] imem_rdata_i;
  logic                issue_valid_o;
  logic [`FE_XLEN-1:0] issue_pc_o;
  logic [`FE_XLEN-1:0] issue_inst_o;
  redirect_src_e       redirect_src_o;

  // program image and event list from the cases file
  logic [31:0] mem_addr [MAX_MEM];
  logic [31:0] mem_word [MAX_MEM];
  int          n_mem;
  int          ev_cycle [MAX_EV];
  string       ev_kind [MAX_EV];
  logic [31:0] ev_pc [MAX_EV];
  logic [31:0] ev_alt [MAX_EV];
  int          n_ev;

  // reference model state
  logic [31:0] exp_pc;      // next pc the stream must issue
  logic [31:0] fetch_pc;    // next sequential fetch address
  int          occ;         // queue occupancy at cycle start
  logic        req_prev;    // request expected last cycle
  logic [31:0] rd_next;     // memory answer for next cycle
  logic [31:0] rnd;
  logic        forced_hold;
  logic        armed;       // redirect waiting for an issued jal
  string       armed_kind;
  logic [31:0] armed_pc;
  int          armed_cycle;
  int          idle;
  int          cyc;
  int          run_cycles;
  int          errors;
  int          checks;
  int          n_issued;
  bit          loaded;

  fetch_frontend fetch_frontend_i (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // unlisted words are lui x0 hints tagged with a hash of the full address
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] w;
    w = {addr[21:2] ^ {10'd0, addr[31:22]}, 5'd0, 7'b0110111};
    for (int i = 0; i < n_mem; i++) begin
      if (mem_addr[i] == addr) w = mem_word[i];
    end
    return w;
  endfunction

  function automatic logic is_jal(input logic [31:0] inst);
    return inst[6:0] == 7'b1101111;
  endfunction

  // J-type offset fields rebuilt into a 21 bit signed offset
  function automatic logic [31:0] jal_target(input logic [31:0] pc, input logic [31:0] inst);
    logic [20:0] off;
    off[20]    = inst[31];
    off[19:12] = inst[19:12];
    off[11]    = inst[20];
    off[10:1]  = inst[30:21];
    off[0]     = 1'b0;
    return pc + {{11{off[20]}}, off};
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s = %h, expected %h at cycle %0d", name, got, exp, cyc);
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    int          cycle_no;
    int          last;
    string       line;
    string       tag;
    string       kind;
    logic [31:0] a;
    logic [31:0] b;
    last = 0;
    fd = $fopen("fetch_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open fetch_cases.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s", tag);  // comment and blank lines fall through
        if (n == 1 && tag == "mem" && n_mem < MAX_MEM) begin
          n = $sscanf(line, "%s %h %h", tag, a, b);
          mem_addr[n_mem] = a;
          mem_word[n_mem] = b;
          n_mem++;
        end else if (n == 1 && tag == "evt" && n_ev < MAX_EV) begin
          n = $sscanf(line, "%s %d %s %h %h", tag, cycle_no, kind, a, b);
          ev_cycle[n_ev] = cycle_no;
          ev_kind[n_ev]  = kind;
          ev_pc[n_ev]    = a;
          ev_alt[n_ev]   = b;
          n_ev++;
          if (cycle_no > last) last = cycle_no;
        end
      end
      $fclose(fd);
    end
    run_cycles = last + TAIL;
  endtask

  task automatic apply_event(input int i);
    if (ev_kind[i] == "trap" || ev_kind[i] == "both") begin
      trap_valid_i = 1'b1;
      trap_pc_i    = ev_pc[i];
    end
    if (ev_kind[i] == "branch") begin
      branch_valid_i = 1'b1;
      branch_pc_i    = ev_pc[i];
    end
    if (ev_kind[i] == "both") begin
      branch_valid_i = 1'b1;
      branch_pc_i    = ev_alt[i];  // loses to the trap
    end
    if (ev_kind[i] == "hold_on") forced_hold = 1'b1;
    if (ev_kind[i] == "hold_off") forced_hold = 1'b0;
    if (ev_kind[i] == "jtrap" || ev_kind[i] == "jbranch") begin
      armed       = 1'b1;
      armed_kind  = ev_kind[i];
      armed_pc    = ev_pc[i];
      armed_cycle = ev_cycle[i];
    end
  endtask

  task automatic drive_cycle(input int c);
    logic random_hold;
    logic jal_next;
    trap_valid_i   = 1'b0;
    branch_valid_i = 1'b0;
    imem_rdata_i   = rd_next;  // answer to last cycle's request
    rnd = xorshift(rnd);
    random_hold = (rnd[2:0] == 3'd0);
    for (int i = 0; i < n_ev; i++) begin
      if (ev_cycle[i] == c) apply_event(i);
    end
    hold_i = forced_hold | random_hold;
    // model predicts a jal leaving the queue this cycle
    jal_next = (occ != 0) && !hold_i && is_jal(word_at(exp_pc));
    if (armed && jal_next) begin
      if (armed_kind == "jtrap") begin
        trap_valid_i = 1'b1;
        trap_pc_i    = armed_pc;
      end else begin
        branch_valid_i = 1'b1;
        branch_pc_i    = armed_pc;
      end
      armed = 1'b0;
    end
  endtask

  task automatic check_cycle(input int c);
    logic          exp_issue;
    logic          jal_now;
    logic          exp_req;
    logic          flush_now;
    logic          wr;
    logic [31:0]   word;
    logic [31:0]   exp_addr;
    redirect_src_e exp_src;
    exp_issue = (occ != 0) && !hold_i;
    word      = word_at(exp_pc);
    jal_now   = exp_issue && is_jal(word);
    exp_req   = (c != 0) && (occ < DEPTH - 1);  // no request in first cycle or almost full
    if (trap_valid_i) exp_src = REDIR_TRAP;
    else if (branch_valid_i) exp_src = REDIR_BRANCH;
    else if (jal_now) exp_src = REDIR_JAL;
    else exp_src = REDIR_SEQ;
    // a redirect target goes out in its own cycle
    if (trap_valid_i) exp_addr = trap_pc_i;
    else if (branch_valid_i) exp_addr = branch_pc_i;
    else if (jal_now) exp_addr = jal_target(exp_pc, word);
    else exp_addr = fetch_pc;
    compare_word("issue_valid_o", issue_valid_o, exp_issue);
    compare_word("imem_req_o", imem_req_o, exp_req);
    compare_word("redirect_src_o", redirect_src_o, exp_src);
    if (exp_req) compare_word("imem_addr_o", imem_addr_o, exp_addr);
    if (issue_valid_o && exp_issue) begin
      compare_word("issue_pc_o", issue_pc_o, exp_pc);
      compare_word("issue_inst_o", issue_inst_o, word);
    end
    fetch_pc  = exp_req ? exp_addr + 32'd4 : exp_addr;  // held until the next request
    flush_now = trap_valid_i | branch_valid_i | jal_now;
    wr        = req_prev & ~flush_now;  // stale response dropped on flush
    if (flush_now) occ = 0;
    else occ = occ + int'(wr) - int'(exp_issue);
    req_prev = exp_req;
    rd_next  = word_at(imem_addr_o);
    if (exp_issue) begin
      n_issued++;
      exp_pc = jal_now ? jal_target(exp_pc, word) : exp_pc + 32'd4;
    end
    if (trap_valid_i) exp_pc = trap_pc_i;
    else if (branch_valid_i) exp_pc = branch_pc_i;
    if (exp_issue || hold_i) idle = 0;
    else idle++;
    assert (idle <= IDLE_MAX) else begin
      errors++;
      $display("no instruction issued for %0d cycles without hold, cycle %0d", idle, c);
      idle = 0;
    end
  endtask

  // hang guard sized from the event list
  initial begin
    wait (loaded);
    #((run_cycles + 50) * PERIOD);
    $display("watchdog expired, the run did not end within %0d cycles", run_cycles + 50);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rst_i          = 1'b1;
    trap_valid_i   = 1'b0;
    trap_pc_i      = '0;
    branch_valid_i = 1'b0;
    branch_pc_i    = '0;
    hold_i         = 1'b0;
    imem_rdata_i   = '0;
    n_mem = 0;
    n_ev = 0;
    errors = 0;
    checks = 0;
    n_issued = 0;
    exp_pc = `FE_PC_RESET;
    fetch_pc = `FE_PC_RESET;
    occ = 0;
    req_prev = 1'b0;
    rd_next = '0;
    rnd = 32'd13439;
    forced_hold = 1'b0;
    armed = 1'b0;
    idle = 0;
    load_cases();
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    #DRV;
    rst_i = 1'b0;
    for (cyc = 0; cyc < run_cycles; cyc++) begin
      if (cyc != 0) begin
        @(posedge clk);
        #DRV;
      end
      drive_cycle(cyc);
      @(negedge clk);  // outputs settled at mid cycle
      check_cycle(cyc);
    end
    assert (!armed) else begin
      errors++;
      $display("%s event from cycle %0d never met an issued jal", armed_kind, armed_cycle);
    end
    $display("%0d checks, %0d instructions issued, %0d errors", checks, n_issued, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: fetch_cases.txt
# mem <addr> <word>            : program image, unlisted words read as nop hints
# evt <cycle> <kind> <pc> <alt> : trap branch both hold_on hold_off jtrap jbranch
# both = trap to pc and branch to alt, jtrap and jbranch fire on the next issued jal
mem 00000000 00100093
mem 00000004 00200113
mem 00000008 002081b3
mem 0000000c 00118213
mem 00000010 0300006f
mem 00000014 00700393
mem 00000018 00800413
mem 00000040 00500293
mem 00000044 00628293
mem 00000048 00128313
mem 0000004c 0062e3b3
mem 00000050 fd1ff06f
mem 00000100 00a00513
mem 00000104 00150513
mem 00000108 ff9ff06f
mem 0000010c 00000073
mem 00000200 00b00593
mem 00000204 00158593
mem 00000208 0f80006f
mem 0000020c 00100073
mem 00000300 0000106f
mem 00001300 804ff06f
evt 40 jbranch 00000200 00000000
evt 70 hold_on 00000000 00000000
evt 80 branch 00000600 00000000
evt 90 hold_off 00000000 00000000
evt 100 branch 00000100 00000000
evt 130 jtrap 00000380 00000000
evt 150 both 00000400 00000480
evt 152 branch 00000700 00000000
evt 170 trap 0000000c 00000000
evt 185 hold_on 00000000 00000000
evt 188 hold_off 00000000 00000000
evt 200 branch 00000500 00000000

// File: all.f
+incdir+.
fe_pkg.sv
pc_gen.sv
fetch_queue.sv
jal_predecode.sv
fetch_frontend.sv
fetch_frontend_tb.sv
